// File: compile.f
hw/board_bus_pkg.sv
hw/alu_op_pkg.sv
hw/io_decode.sv
hw/carry_adder.sv
hw/logic_unit.sv
hw/alu_core.sv
hw/register_bank.sv
hw/board_top.sv
bench/board_top_tb.sv

// File: bench/board_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_top_tb;
  import board_bus_pkg::*;
  import alu_op_pkg::*;

  logic              clk;
  logic              clear;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] data_in;
  logic              wr;
  logic              rd;
  logic [data_w-1:0] data_out;

  integer seed = 61991;
  integer errors = 0;

  // shadow copies of the card registers
  logic [data_w-1:0] m_a;
  logic [data_w-1:0] m_b;
  logic [2:0]        m_op;
  logic              m_c;  // carry flag
  logic              m_z;  // zero flag

  board_top u_dut (
    .clk      (clk),
    .clear    (clear),
    .addr     (addr),
    .data_in  (data_in),
    .wr       (wr),
    .rd       (rd),
    .data_out (data_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog over the whole run
  initial begin
    #2_000_000;
    $display("timeout: the run did not reach its end in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [addr_w-1:0] card_addr(input logic [2:0] off);
    return {card_base, off};
  endfunction

  task automatic wait_cycles(input int n);
    int count;
    count = 0;
    while (count < n && count < 1000) begin  // bounded edge count
      @(posedge clk);
      count++;
    end
    if (count < n) begin
      $display("wait_cycles gave up after %0d of %0d cycles", count, n);
      errors++;
    end
  endtask

  // wr stays high until the next bus task, so writes can go back to back
  task automatic bus_write(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    @(posedge clk);
    addr    <= a;
    data_in <= d;
    wr      <= 1'b1;
    rd      <= 1'b0;
  endtask

  task automatic bus_read(input logic [addr_w-1:0] a, output logic [data_w-1:0] got);
    @(posedge clk);
    wr   <= 1'b0;
    addr <= a;
    rd   <= 1'b1;
    @(negedge clk);  // mid cycle, data_out settled
    got = data_out;
  endtask

  task automatic expect_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic read_expect(input logic [addr_w-1:0] a, input logic [7:0] exp,
                             input string what);
    logic [7:0] got;
    bus_read(a, got);
    expect_byte(got, exp, what);
  endtask

  task automatic check_all(input string what);
    read_expect(card_addr(reg_a_off), m_a, {what, ": acc"});
    read_expect(card_addr(reg_b_off), m_b, {what, ": operand b"});
    read_expect(card_addr(reg_op_off), {5'b0, m_op}, {what, ": opcode"});
    read_expect(card_addr(reg_flags_off), {6'b0, m_z, m_c}, {what, ": flags"});
  endtask

  // load operands, run one opcode, then compare acc and flags
  task automatic run_op(input alu_op_e op, input logic [7:0] a, input logic [7:0] b);
    logic [8:0] wide;  // {carry, result}
    bus_write(card_addr(reg_a_off), a);
    bus_write(card_addr(reg_b_off), b);
    bus_write(card_addr(reg_op_off), {5'b0, op});
    bus_write(card_addr(reg_exec_off), 8'h00);
    m_b  = b;
    m_op = op;
    case (op)
      op_add:  wide = {1'b0, a} + {1'b0, b};
      op_adc:  wide = {1'b0, a} + {1'b0, b} + m_c;  // previous carry
      op_sub:  wide = {(a >= b), a - b};  // carry = no borrow
      op_and:  wide = {1'b0, a & b};
      op_or:   wide = {1'b0, a | b};
      op_xor:  wide = {1'b0, a ^ b};
      op_nand: wide = {1'b0, ~(a & b)};
      default: wide = {1'b0, b};
    endcase
    m_a = wide[7:0];
    m_c = wide[8];
    m_z = (m_a == 8'h00);
    read_expect(card_addr(reg_a_off), m_a, $sformatf("%s acc", op.name()));
    read_expect(card_addr(reg_flags_off), {6'b0, m_z, m_c}, $sformatf("%s flags", op.name()));
  endtask

  initial begin
    logic [7:0] ra;
    logic [7:0] rb;
    clear   = 1'b0;
    addr    = '0;
    data_in = '0;
    wr      = 1'b0;
    rd      = 1'b0;
    m_a     = '0;
    m_b     = '0;
    m_op    = '0;
    m_c     = 1'b0;
    m_z     = 1'b0;
    wait_cycles(10);
    clear <= 1'b1;  // released on a rising edge
    check_all("after reset");

    // plain register writes, opcode keeps 3 bits
    bus_write(card_addr(reg_a_off), 8'h5a);
    bus_write(card_addr(reg_b_off), 8'hc3);
    bus_write(card_addr(reg_op_off), 8'hfe);
    m_a  = 8'h5a;
    m_b  = 8'hc3;
    m_op = 3'd6;
    check_all("register writes");
    bus_write(card_addr(reg_op_off), 8'h0b);  // back to back, last one wins
    bus_write(card_addr(reg_op_off), 8'h74);
    m_op = 3'd4;
    check_all("back to back opcode");
    for (int i = 0; i < 8; i++) begin
      ra = $random(seed);
      rb = $random(seed);
      bus_write(card_addr(reg_a_off), ra);
      bus_write(card_addr(reg_b_off), rb);
      bus_write(card_addr(reg_op_off), rb ^ ra);
      m_a  = ra;
      m_b  = rb;
      m_op = rb[2:0] ^ ra[2:0];
      check_all("random writes");
    end

    // arithmetic, adc after both carry states
    run_op(op_add, 8'hff, 8'h01);  // carry set, zero set
    run_op(op_adc, 8'h10, 8'h20);
    run_op(op_add, 8'h01, 8'h01);  // carry clear
    run_op(op_adc, 8'h10, 8'h20);
    run_op(op_sub, 8'h42, 8'h42);
    run_op(op_sub, 8'h10, 8'h20);  // borrow
    for (int i = 0; i < 200; i++) begin
      ra = $random(seed);
      rb = $random(seed);
      case (i % 4)
        0:       run_op(op_add, ra, rb);
        2:       run_op(op_sub, ra, rb);
        default: run_op(op_adc, ra, rb);
      endcase
    end

    // logic opcodes and pass b, carry must read 0
    for (int i = 0; i < 20; i++) begin
      for (int k = 3; k < 8; k++) begin
        ra = $random(seed);
        rb = $random(seed);
        run_op(alu_op_e'(k), ra, rb);
      end
    end

    // stray writes and reads
    bus_write(card_addr(reg_a_off), 8'ha5);
    m_a = 8'ha5;
    bus_write({5'b00111, reg_a_off}, 8'h99);  // other card
    bus_write({~card_base, reg_b_off}, 8'h66);
    bus_write(card_addr(3'd5), 8'h11);  // unused offsets
    bus_write(card_addr(3'd6), 8'h22);
    bus_write(card_addr(3'd7), 8'h33);
    bus_write(card_addr(reg_flags_off), 8'hff);  // flags are read only
    check_all("after stray writes");
    read_expect({5'b01010, reg_a_off}, 8'h00, "off card read");
    read_expect(card_addr(3'd6), 8'h00, "unused offset read");
    read_expect(card_addr(reg_exec_off), 8'h00, "exec read");
    @(posedge clk);
    rd   <= 1'b0;
    addr <= card_addr(reg_a_off);
    @(negedge clk);
    expect_byte(data_out, 8'h00, "read with rd low");

    @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/board_top.sv
`timescale 1ns/1ps
`default_nettype none

// alu card top, decoder + register bank + alu
module board_top (
  input  logic                             clk,
  input  logic                             clear,
  input  logic [board_bus_pkg::addr_w-1:0] addr,
  input  logic [board_bus_pkg::data_w-1:0] data_in,
  input  logic                             wr,
  input  logic                             rd,
  output logic [board_bus_pkg::data_w-1:0] data_out
);
  import board_bus_pkg::*;
  import alu_op_pkg::*;

  // decoder strobes
  logic wr_a, wr_b, wr_op, wr_exec;
  logic rd_a, rd_b, rd_op, rd_flags;

  // register bank to alu and back
  logic [data_w-1:0] acc;
  logic [data_w-1:0] opnd_b;
  alu_op_e           opcode;
  logic              carry_flag;
  logic [data_w-1:0] alu_result;
  logic              alu_carry;
  logic              alu_zero;

  io_decode u_decode (
    .addr     (addr),
    .wr       (wr),
    .rd       (rd),
    .wr_a     (wr_a),
    .wr_b     (wr_b),
    .wr_op    (wr_op),
    .wr_exec  (wr_exec),
    .rd_a     (rd_a),
    .rd_b     (rd_b),
    .rd_op    (rd_op),
    .rd_flags (rd_flags)
  );

  register_bank u_regs (
    .clk        (clk),
    .clear      (clear),
    .wr_a       (wr_a),
    .wr_b       (wr_b),
    .wr_op      (wr_op),
    .wr_exec    (wr_exec),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .rd_op      (rd_op),
    .rd_flags   (rd_flags),
    .data_in    (data_in),
    .alu_result (alu_result),
    .alu_carry  (alu_carry),
    .alu_zero   (alu_zero),
    .acc        (acc),
    .opnd_b     (opnd_b),
    .opcode     (opcode),
    .carry_flag (carry_flag),
    .data_out   (data_out)
  );

  alu_core u_alu (
    .acc        (acc),
    .opnd_b     (opnd_b),
    .opcode     (opcode),
    .carry_flag (carry_flag),
    .alu_result (alu_result),
    .alu_carry  (alu_carry),
    .alu_zero   (alu_zero)
  );

endmodule

`default_nettype wire

// File: hw/register_bank.sv
`timescale 1ns/1ps
`default_nettype none

// 74175 style register file with clear, plus the read back mux
module register_bank (
  input  logic                             clk,
  input  logic                             clear,
  input  logic                             wr_a,
  input  logic                             wr_b,
  input  logic                             wr_op,
  input  logic                             wr_exec,
  input  logic                             rd_a,
  input  logic                             rd_b,
  input  logic                             rd_op,
  input  logic                             rd_flags,
  input  logic [board_bus_pkg::data_w-1:0] data_in,
  input  logic [board_bus_pkg::data_w-1:0] alu_result,
  input  logic                             alu_carry,
  input  logic                             alu_zero,
  output logic [board_bus_pkg::data_w-1:0] acc,
  output logic [board_bus_pkg::data_w-1:0] opnd_b,
  output alu_op_pkg::alu_op_e              opcode,
  output logic                             carry_flag,
  output logic [board_bus_pkg::data_w-1:0] data_out
);
  import board_bus_pkg::*;
  import alu_op_pkg::*;

  logic [flag_w-1:0] flags;  // {zero, carry}

  // accumulator, bus load or alu result
  always_ff @(posedge clk or negedge clear) begin
    if (!clear) begin
      acc <= '0;
    end else if (wr_exec) begin
      acc <= alu_result;
    end else if (wr_a) begin
      acc <= data_in;
    end
  end

  always_ff @(posedge clk or negedge clear) begin
    if (!clear) begin
      opnd_b <= '0;
    end else if (wr_b) begin
      opnd_b <= data_in;
    end
  end

  // opcode keeps the low 3 bits only
  always_ff @(posedge clk or negedge clear) begin
    if (!clear) begin
      opcode <= op_add;
    end else if (wr_op) begin
      opcode <= alu_op_e'(data_in[2:0]);
    end
  end

  // flags only move on execute
  always_ff @(posedge clk or negedge clear) begin
    if (!clear) begin
      flags <= '0;
    end else if (wr_exec) begin
      flags <= {alu_zero, alu_carry};
    end
  end

  assign carry_flag = flags[0];

  // gated read mux, zero when nothing selected
  always_comb begin
    if (rd_a)
      data_out = acc;
    else if (rd_b)
      data_out = opnd_b;
    else if (rd_op)
      data_out = {{(data_w - $bits(alu_op_e)){1'b0}}, opcode};  // zero extend
    else if (rd_flags)
      data_out = {{(data_w - flag_w){1'b0}}, flags};
    else
      data_out = '0;
  end

  // decoder must never ask for two acc sources at once
  a_acc_one_source: assert property (@(posedge clk) disable iff (!clear)
    !(wr_a && wr_exec))
    else $error("register_bank: wr_a and wr_exec in the same cycle");

  // zero flag tracks the value actually loaded into acc
  a_zero_matches: assert property (@(posedge clk) disable iff (!clear)
    wr_exec |=> (flags[1] == (acc == '0)))
    else $error("register_bank: zero flag disagrees with accumulator");

endmodule

`default_nettype wire

// File: hw/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

// alu datapath, adder or truth-table unit picked by opcode
module alu_core (
  input  logic [board_bus_pkg::data_w-1:0] acc,
  input  logic [board_bus_pkg::data_w-1:0] opnd_b,
  input  alu_op_pkg::alu_op_e              opcode,
  input  logic                             carry_flag,  // stored carry for adc
  output logic [board_bus_pkg::data_w-1:0] alu_result,
  output logic                             alu_carry,
  output logic                             alu_zero
);
  import board_bus_pkg::*;
  import alu_op_pkg::*;

  logic [data_w-1:0] add_sum;
  logic [data_w-1:0] logic_y;
  logic              add_c;
  logic              add_cin;
  logic              add_inv;
  logic              is_arith;  // result comes from the adder
  logic [3:0]        tt_sel;    // truth table to the 74153 row

  // opcode to adder controls and truth table
  always_comb begin
    is_arith = 1'b0;
    add_cin  = 1'b0;
    add_inv  = 1'b0;
    tt_sel   = tt_pass_b;
    case (opcode)
      op_add: is_arith = 1'b1;
      op_adc: begin
        is_arith = 1'b1;
        add_cin  = carry_flag;
      end
      op_sub: begin
        is_arith = 1'b1;  // a + ~b + 1
        add_inv  = 1'b1;
        add_cin  = 1'b1;
      end
      op_and:  tt_sel = tt_and;
      op_or:   tt_sel = tt_or;
      op_xor:  tt_sel = tt_xor;
      op_nand: tt_sel = tt_nand;
      default: tt_sel = tt_pass_b;  // op_pass_b
    endcase
  end

  carry_adder u_adder (
    .a        (acc),
    .b        (opnd_b),
    .c_in     (add_cin),
    .invert_b (add_inv),
    .sum      (add_sum),
    .c_out    (add_c)
  );

  logic_unit u_logic (
    .a          (acc),
    .b          (opnd_b),
    .table_bits (tt_sel),
    .y          (logic_y)
  );

  assign alu_result = is_arith ? add_sum : logic_y;
  assign alu_carry  = is_arith & add_c;  // logic ops clear carry
  assign alu_zero   = (alu_result == '0);

  // a stale carry after a logic op would corrupt a following adc
  a_logic_no_carry: assert final ($isunknown(opcode) ||
                                  !(opcode inside {op_and, op_or, op_xor, op_nand, op_pass_b}) ||
                                  !alu_carry)
    else $error("alu_core: carry set on logic opcode %s", opcode.name());

endmodule

`default_nettype wire

// File: hw/logic_unit.sv
`timescale 1ns/1ps
`default_nettype none

// function generator, one 4:1 mux per bit like a 74153 row
// b and a drive the select pins, table_bits drive D0..D3
module logic_unit (
  input  logic [board_bus_pkg::data_w-1:0] a,
  input  logic [board_bus_pkg::data_w-1:0] b,
  input  logic [3:0]                       table_bits,
  output logic [board_bus_pkg::data_w-1:0] y
);
  import board_bus_pkg::*;

  always_comb begin
    for (int i = 0; i < data_w; i++) begin
      case ({b[i], a[i]})
        2'b00:   y[i] = table_bits[0];  // D0
        2'b01:   y[i] = table_bits[1];  // D1
        2'b10:   y[i] = table_bits[2];  // D2
        default: y[i] = table_bits[3];  // D3, both high
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/carry_adder.sv
`timescale 1ns/1ps
`default_nettype none

// 8 bit adder, two 74283 nibble stages with rippled carry
module carry_adder (
  input  logic [board_bus_pkg::data_w-1:0] a,
  input  logic [board_bus_pkg::data_w-1:0] b,
  input  logic                             c_in,
  input  logic                             invert_b,  // ones complement b for sub
  output logic [board_bus_pkg::data_w-1:0] sum,
  output logic                             c_out
);
  import board_bus_pkg::*;

  logic [data_w-1:0] b_eff;  // b after the xor row
  logic              c_mid;  // low chip c4 into high chip c0

  always_comb begin
    b_eff = invert_b ? ~b : b;
    // low nibble chip
    {c_mid, sum[3:0]} = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0, c_in};
    // high nibble chip
    {c_out, sum[data_w-1:4]} = {1'b0, a[data_w-1:4]} + {1'b0, b_eff[data_w-1:4]}
                               + {4'b0, c_mid};
  end

endmodule

`default_nettype wire

// File: hw/io_decode.sv
`timescale 1ns/1ps
`default_nettype none

// card i/o decoder, one 74138 plus the strobe gating
module io_decode (
  input  logic [board_bus_pkg::addr_w-1:0] addr,
  input  logic                             wr,    // one cycle pulse
  input  logic                             rd,    // level
  output logic                             wr_a,
  output logic                             wr_b,
  output logic                             wr_op,
  output logic                             wr_exec,
  output logic                             rd_a,
  output logic                             rd_b,
  output logic                             rd_op,
  output logic                             rd_flags
);
  import board_bus_pkg::*;

  logic       g_en;  // chip enable, card base match
  logic [7:0] y_n;   // active low selects, y5..y7 left open

  assign g_en = (addr[addr_w-1:3] == card_base);

  // 3 to 8 decode of the low address bits
  always_comb begin
    y_n = 8'hff;
    if (g_en)
      y_n[addr[2:0]] = 1'b0;
  end

  // gate selects into active high strobes
  assign wr_a     = wr & ~y_n[reg_a_off];
  assign wr_b     = wr & ~y_n[reg_b_off];
  assign wr_op    = wr & ~y_n[reg_op_off];
  assign wr_exec  = wr & ~y_n[reg_exec_off];  // no read path for exec
  assign rd_a     = rd & ~y_n[reg_a_off];
  assign rd_b     = rd & ~y_n[reg_b_off];
  assign rd_op    = rd & ~y_n[reg_op_off];
  assign rd_flags = rd & ~y_n[reg_flags_off];  // flags never written from the bus

  // register bank relies on one load source per cycle
  a_wr_onehot: assert final ($onehot0({wr_a, wr_b, wr_op, wr_exec}))
    else $error("io_decode: more than one write strobe active");

endmodule

`default_nettype wire

// File: hw/alu_op_pkg.sv
`default_nettype none

// alu opcodes and the 74153 truth tables for the logic ops
package alu_op_pkg;

  typedef enum logic [2:0] {
    op_add    = 3'd0,  // a + b
    op_adc    = 3'd1,  // a + b + stored carry
    op_sub    = 3'd2,  // a - b, carry set = no borrow
    op_and    = 3'd3,
    op_or     = 3'd4,
    op_xor    = 3'd5,
    op_nand   = 3'd6,
    op_pass_b = 3'd7   // result is b
  } alu_op_e;

  // truth tables, index {b,a} picks the result bit
  // bit 0 = D0 (b=0 a=0) ... bit 3 = D3 (b=1 a=1)
  localparam logic [3:0] tt_and    = 4'b1000;
  localparam logic [3:0] tt_or     = 4'b1110;
  localparam logic [3:0] tt_xor    = 4'b0110;
  localparam logic [3:0] tt_nand   = 4'b0111;
  localparam logic [3:0] tt_pass_b = 4'b1100;  // follows b only

  // flag register, bit 0 carry, bit 1 zero
  localparam int flag_w = 2;

endpackage

`default_nettype wire

// File: hw/board_bus_pkg.sv
`default_nettype none

// host bus geometry and the card's register map
package board_bus_pkg;

  // bus widths
  localparam int data_w = 8;  // data bus, one byte
  localparam int addr_w = 8;  // address bus, one byte

  // card select, compared against addr[7:3]
  localparam logic [4:0] card_base = 5'b10100;

  // register offsets on addr[2:0]
  localparam logic [2:0] reg_a_off     = 3'd0;  // accumulator
  localparam logic [2:0] reg_b_off     = 3'd1;  // operand b
  localparam logic [2:0] reg_op_off    = 3'd2;  // opcode
  localparam logic [2:0] reg_exec_off  = 3'd3;  // execute strobe, write only
  localparam logic [2:0] reg_flags_off = 3'd4;  // {zero, carry}, read only

  // offsets 5..7 are not decoded

endpackage

`default_nettype wire
